// ==== hw/cmd_pkg.sv ====
package cmd_pkg;

    typedef logic [7:0] byte_t;

    // ==================================================
    // frame format and command codes
    // ==================================================
    localparam byte_t SYNC_BYTE = 8'hA5;

    localparam byte_t CMD_PWM  = 8'h01;
    localparam byte_t CMD_UART = 8'h02;
    localparam byte_t CMD_DAC  = 8'h03;
    localparam byte_t CMD_LED  = 8'h04;
    localparam byte_t CMD_ECHO = 8'h05;

    // ==================================================
    // peripheral sizes
    // ==================================================
    localparam int NUM_PWM = 8;
    localparam int PWM_W   = 8;
    localparam int DAC_W   = 14;

    typedef logic [DAC_W-1:0] dac_t;

    // ==================================================
    // uart timing
    // ==================================================
    // short bit time so simulation stays fast
    localparam int CLKS_PER_BIT = 16;
    localparam int HALF_BIT     = CLKS_PER_BIT / 2;
    localparam int CLK_CNT_W    = $clog2(CLKS_PER_BIT);

endpackage

// ==== hw/frame_parser.sv ====
`timescale 1ns/1ps

module frame_parser (
    input  logic           clk,
    input  logic           reset_i,
    input  cmd_pkg::byte_t host_data_i,
    input  logic           host_valid_i,
    input  logic           tx_busy_i,
    output logic           pwm_we_o,
    output logic [2:0]     pwm_ch_o,
    output cmd_pkg::byte_t pwm_duty_o,
    output logic           tx_start_o,
    output cmd_pkg::byte_t tx_data_o,
    output logic           echo_valid_o,
    output cmd_pkg::byte_t echo_data_o,
    output cmd_pkg::dac_t  dac_data_o,
    output logic           led_o
);
    import cmd_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_CMD,
        ST_ARG,
        ST_DATA
    } state_t;

    state_t state_q;
    byte_t  cmd_q;
    byte_t  arg_q;
    byte_t  data_q;
    logic   last_byte;
    logic   dac_we_q;
    logic   led_we_q;
    dac_t   dac_q;
    logic   led_q;

    // data byte of a frame is on the bus
    assign last_byte = host_valid_i && (state_q == ST_DATA);

    // ==================================================
    // frame state machine
    // ==================================================
    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q <= ST_IDLE;
        end else if (host_valid_i) begin
            case (state_q)
                // anything but sync is ignored here
                ST_IDLE: if (host_data_i == SYNC_BYTE) state_q <= ST_CMD;
                ST_CMD:  state_q <= ST_ARG;
                ST_ARG:  state_q <= ST_DATA;
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    // frame fields
    always_ff @(posedge clk) begin
        if (host_valid_i && state_q == ST_CMD) cmd_q <= host_data_i;
        if (host_valid_i && state_q == ST_ARG) arg_q <= host_data_i;
        if (last_byte) data_q <= host_data_i;
    end

    // ==================================================
    // command decode
    // ==================================================
    // unknown codes raise no strobe at all
    always_ff @(posedge clk) begin
        if (reset_i) begin
            pwm_we_o     <= 1'b0;
            tx_start_o   <= 1'b0;
            echo_valid_o <= 1'b0;
            dac_we_q     <= 1'b0;
            led_we_q     <= 1'b0;
        end else begin
            pwm_we_o     <= last_byte && (cmd_q == CMD_PWM);
            // uart byte lost if the transmitter is still busy
            tx_start_o   <= last_byte && (cmd_q == CMD_UART) && !tx_busy_i;
            echo_valid_o <= last_byte && (cmd_q == CMD_ECHO);
            dac_we_q     <= last_byte && (cmd_q == CMD_DAC);
            led_we_q     <= last_byte && (cmd_q == CMD_LED);
        end
    end

    // local dac and led registers, one edge after the strobe
    always_ff @(posedge clk) begin
        if (reset_i) begin
            dac_q <= '0;
            led_q <= 1'b0;
        end else begin
            if (dac_we_q) dac_q <= {arg_q[5:0], data_q};
            if (led_we_q) led_q <= data_q[0];
        end
    end

    assign pwm_ch_o    = arg_q[2:0];
    assign pwm_duty_o  = data_q;
    assign tx_data_o   = data_q;
    assign echo_data_o = data_q;
    assign dac_data_o  = dac_q;
    assign led_o       = led_q;

endmodule

// ==== hw/pwm_bank.sv ====
`timescale 1ns/1ps

module pwm_bank (
    input  logic                        clk,
    input  logic                        reset_i,
    input  logic                        pwm_we_i,
    input  logic [2:0]                  pwm_ch_i,
    input  cmd_pkg::byte_t              pwm_duty_i,
    output logic [cmd_pkg::NUM_PWM-1:0] pwm_pins_o
);
    import cmd_pkg::*;

    logic [PWM_W-1:0] duty_q [NUM_PWM];
    logic [PWM_W-1:0] cnt_q;

    // shared free-running counter, wraps at 255
    always_ff @(posedge clk) begin
        if (reset_i) begin
            cnt_q <= '0;
        end else begin
            cnt_q <= cnt_q + 1'b1;
        end
    end

    // duty registers start at zero so every pin is low
    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 0; i < NUM_PWM; i++) begin
                duty_q[i] <= '0;
            end
        end else if (pwm_we_i) begin
            duty_q[pwm_ch_i] <= pwm_duty_i;
        end
    end

    // high while the count is below the duty
    always_comb begin
        for (int i = 0; i < NUM_PWM; i++) begin
            pwm_pins_o[i] = (cnt_q < duty_q[i]);
        end
    end

endmodule

// ==== hw/uart_bridge.sv ====
`timescale 1ns/1ps

module uart_bridge (
    input  logic           clk,
    input  logic           reset_i,
    input  logic           tx_start_i,
    input  cmd_pkg::byte_t tx_data_i,
    output logic           tx_busy_o,
    output logic           uart_tx_o,
    input  logic           uart_rx_i,
    output logic           rx_valid_o,
    output cmd_pkg::byte_t rx_data_o
);
    import cmd_pkg::*;

    logic [8:0]           tx_shift_q;
    logic [3:0]           tx_bits_q;
    logic [CLK_CNT_W-1:0] tx_cnt_q;
    logic                 tx_line_q;
    logic                 tx_busy_q;
    logic                 tx_bit_done;

    logic                 rx_s1_q;
    logic                 rx_s2_q;
    logic                 rx_prev_q;
    logic                 rx_busy_q;
    logic [3:0]           rx_bits_q;
    logic [CLK_CNT_W-1:0] rx_cnt_q;
    logic [CLK_CNT_W-1:0] rx_limit;
    logic                 rx_sample;
    byte_t                rx_shift_q;
    logic                 rx_valid_q;

    // ==================================================
    // transmitter
    // ==================================================
    assign tx_bit_done = (tx_cnt_q == CLK_CNT_W'(CLKS_PER_BIT - 1));

    // bit 0 is the start bit, 1..8 data, 9 the stop bit
    always_ff @(posedge clk) begin
        if (reset_i) begin
            tx_busy_q <= 1'b0;
            tx_line_q <= 1'b1;
            tx_bits_q <= '0;
            tx_cnt_q  <= '0;
        end else if (!tx_busy_q) begin
            if (tx_start_i) begin
                tx_busy_q <= 1'b1;
                tx_line_q <= 1'b0;
                tx_bits_q <= '0;
                tx_cnt_q  <= '0;
            end
        end else if (tx_bit_done) begin
            tx_cnt_q <= '0;
            if (tx_bits_q == 4'd9) begin
                tx_busy_q <= 1'b0;
            end else begin
                tx_line_q <= tx_shift_q[0];
                tx_bits_q <= tx_bits_q + 4'd1;
            end
        end else begin
            tx_cnt_q <= tx_cnt_q + 1'b1;
        end
    end

    // stop bit sits above the data, shifted out lsb first
    always_ff @(posedge clk) begin
        if (!tx_busy_q && tx_start_i) begin
            tx_shift_q <= {1'b1, tx_data_i};
        end else if (tx_busy_q && tx_bit_done) begin
            tx_shift_q <= tx_shift_q >> 1;
        end
    end

    assign tx_busy_o = tx_busy_q;
    assign uart_tx_o = tx_line_q;

    // ==================================================
    // receiver
    // ==================================================
    always_ff @(posedge clk) begin
        if (reset_i) begin
            rx_s1_q   <= 1'b1;
            rx_s2_q   <= 1'b1;
            rx_prev_q <= 1'b1;
        end else begin
            rx_s1_q   <= uart_rx_i;
            rx_s2_q   <= rx_s1_q;
            rx_prev_q <= rx_s2_q;
        end
    end

    // half a bit to the start bit middle, then whole bits
    assign rx_limit  = (rx_bits_q == 4'd0) ? CLK_CNT_W'(HALF_BIT - 1)
                                           : CLK_CNT_W'(CLKS_PER_BIT - 1);
    assign rx_sample = rx_busy_q && (rx_cnt_q == rx_limit);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            rx_busy_q  <= 1'b0;
            rx_bits_q  <= '0;
            rx_cnt_q   <= '0;
            rx_valid_q <= 1'b0;
        end else begin
            rx_valid_q <= 1'b0;
            if (!rx_busy_q) begin
                if (rx_prev_q && !rx_s2_q) begin
                    rx_busy_q <= 1'b1;
                    rx_bits_q <= '0;
                    rx_cnt_q  <= '0;
                end
            end else if (rx_sample) begin
                rx_cnt_q <= '0;
                if (rx_bits_q == 4'd0 && rx_s2_q) begin
                    // start bit gone by mid-bit, treat as glitch
                    rx_busy_q <= 1'b0;
                end else if (rx_bits_q == 4'd9) begin
                    rx_busy_q  <= 1'b0;
                    rx_valid_q <= rx_s2_q;
                end else begin
                    rx_bits_q <= rx_bits_q + 4'd1;
                end
            end else begin
                rx_cnt_q <= rx_cnt_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rx_sample && rx_bits_q != 4'd0 && rx_bits_q != 4'd9) begin
            rx_shift_q <= {rx_s2_q, rx_shift_q[7:1]};
        end
    end

    assign rx_valid_o = rx_valid_q;
    assign rx_data_o  = rx_shift_q;

endmodule

// ==== hw/upload_arbiter.sv ====
`timescale 1ns/1ps

module upload_arbiter (
    input  logic           clk,
    input  logic           reset_i,
    input  logic           rx_valid_i,
    input  cmd_pkg::byte_t rx_data_i,
    input  logic           echo_valid_i,
    input  cmd_pkg::byte_t echo_data_i,
    output cmd_pkg::byte_t upload_data_o,
    output logic           upload_valid_o
);
    import cmd_pkg::*;

    logic  hold_valid_q;
    byte_t hold_data_q;

    // ==================================================
    // upload select, rx first then held echo then new echo
    // ==================================================
    always_ff @(posedge clk) begin
        if (reset_i) begin
            upload_valid_o <= 1'b0;
            hold_valid_q   <= 1'b0;
        end else begin
            upload_valid_o <= rx_valid_i || hold_valid_q || echo_valid_i;
            if (rx_valid_i) begin
                // echo loses this slot and waits
                if (echo_valid_i) hold_valid_q <= 1'b1;
            end else if (hold_valid_q) begin
                hold_valid_q <= echo_valid_i;
            end
        end
    end

    // payload path
    always_ff @(posedge clk) begin
        if (rx_valid_i) begin
            upload_data_o <= rx_data_i;
        end else if (hold_valid_q) begin
            upload_data_o <= hold_data_q;
        end else if (echo_valid_i) begin
            upload_data_o <= echo_data_i;
        end
        if (echo_valid_i && (rx_valid_i || hold_valid_q)) begin
            hold_data_q <= echo_data_i;
        end
    end

endmodule

// ==== hw/cmd_top.sv ====
`timescale 1ns/1ps

module cmd_top (
    input  logic                        clk,
    input  logic                        reset_i,
    input  cmd_pkg::byte_t              host_data_i,
    input  logic                        host_valid_i,
    output cmd_pkg::byte_t              upload_data_o,
    output logic                        upload_valid_o,
    output logic [cmd_pkg::NUM_PWM-1:0] pwm_pins_o,
    input  logic                        uart_rx_i,
    output logic                        uart_tx_o,
    output cmd_pkg::dac_t               dac_data_o,
    output logic                        led_o
);
    import cmd_pkg::*;

    // parser to pwm bank
    logic       pwm_we;
    logic [2:0] pwm_ch;
    byte_t      pwm_duty;

    // parser and uart
    logic       tx_start;
    byte_t      tx_data;
    logic       tx_busy;

    // upload sources
    logic       echo_valid;
    byte_t      echo_data;
    logic       rx_valid;
    byte_t      rx_data;

    // ==================================================
    // command processor
    // ==================================================
    frame_parser u_frame_parser (
        .clk          (clk),
        .reset_i      (reset_i),
        .host_data_i  (host_data_i),
        .host_valid_i (host_valid_i),
        .tx_busy_i    (tx_busy),
        .pwm_we_o     (pwm_we),
        .pwm_ch_o     (pwm_ch),
        .pwm_duty_o   (pwm_duty),
        .tx_start_o   (tx_start),
        .tx_data_o    (tx_data),
        .echo_valid_o (echo_valid),
        .echo_data_o  (echo_data),
        .dac_data_o   (dac_data_o),
        .led_o        (led_o)
    );

    // ==================================================
    // peripherals
    // ==================================================
    pwm_bank u_pwm_bank (
        .clk        (clk),
        .reset_i    (reset_i),
        .pwm_we_i   (pwm_we),
        .pwm_ch_i   (pwm_ch),
        .pwm_duty_i (pwm_duty),
        .pwm_pins_o (pwm_pins_o)
    );

    uart_bridge u_uart_bridge (
        .clk        (clk),
        .reset_i    (reset_i),
        .tx_start_i (tx_start),
        .tx_data_i  (tx_data),
        .tx_busy_o  (tx_busy),
        .uart_tx_o  (uart_tx_o),
        .uart_rx_i  (uart_rx_i),
        .rx_valid_o (rx_valid),
        .rx_data_o  (rx_data)
    );

    upload_arbiter u_upload_arbiter (
        .clk            (clk),
        .reset_i        (reset_i),
        .rx_valid_i     (rx_valid),
        .rx_data_i      (rx_data),
        .echo_valid_i   (echo_valid),
        .echo_data_i    (echo_data),
        .upload_data_o  (upload_data_o),
        .upload_valid_o (upload_valid_o)
    );

endmodule

// ==== verif/cmd_props.sv ====
`timescale 1ns/1ps

module cmd_props (
    input logic                        clk,
    input logic                        reset_i,
    input logic                        upload_valid_i,
    input logic                        led_i,
    input logic                        uart_tx_i,
    input logic [cmd_pkg::NUM_PWM-1:0] pwm_pins_i,
    input logic                        pwm_we_i,
    input logic [2:0]                  pwm_ch_i,
    input cmd_pkg::byte_t              pwm_duty_i,
    input cmd_pkg::dac_t               dac_data_i,
    input logic                        last_byte_i,
    input cmd_pkg::byte_t              cmd_i
);
    import cmd_pkg::*;

    // channels whose last written duty is zero
    logic [NUM_PWM-1:0] zero_duty_q;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            zero_duty_q <= '1;
        end else if (pwm_we_i) begin
            zero_duty_q[pwm_ch_i] <= (pwm_duty_i == '0);
        end
    end

    // ==================================================
    // reset values
    // ==================================================
    a_reset_idle: assert property (@(posedge clk)
        $past(reset_i) && !reset_i |-> !upload_valid_i && !led_i && uart_tx_i)
        else $error("outputs not idle right after reset");

    // zero duty keeps a pin low
    for (genvar i = 0; i < NUM_PWM; i++) begin : g_pin
        a_zero_duty: assert property (@(posedge clk) disable iff (reset_i)
            zero_duty_q[i] |-> !pwm_pins_i[i])
            else $error("pwm pin %0d high with zero duty", i);
    end

    // dac output moves two edges after the final byte of a dac frame
    a_dac_write: assert property (@(posedge clk) disable iff (reset_i)
        dac_data_i != $past(dac_data_i) |-> $past(last_byte_i && (cmd_i == CMD_DAC), 2))
        else $error("dac_data_o changed without a dac frame");

endmodule

bind cmd_top cmd_props i_props (
    .clk            (clk),
    .reset_i        (reset_i),
    .upload_valid_i (upload_valid_o),
    .led_i          (led_o),
    .uart_tx_i      (uart_tx_o),
    .pwm_pins_i     (pwm_pins_o),
    .pwm_we_i       (pwm_we),
    .pwm_ch_i       (pwm_ch),
    .pwm_duty_i     (pwm_duty),
    .dac_data_i     (dac_data_o),
    .last_byte_i    (u_frame_parser.last_byte),
    .cmd_i          (u_frame_parser.cmd_q)
);

// ==== verif/cmd_tb.sv ====
`timescale 1ns/1ps

module cmd_tb;
    import cmd_pkg::*;

    localparam int RESET_CYCLES   = 4;
    localparam int UPLOAD_TIMEOUT = 40 * CLKS_PER_BIT;
    localparam int RUN_LIMIT      = 200000;

    logic               clk;
    logic               reset_i;
    byte_t              host_data_i;
    logic               host_valid_i;
    byte_t              upload_data_o;
    logic               upload_valid_o;
    logic [NUM_PWM-1:0] pwm_pins_o;
    logic               uart_rx_i;
    logic               uart_tx_o;
    dac_t               dac_data_o;
    logic               led_o;

    // reference model state
    dac_t  exp_dac;
    logic  exp_led;
    byte_t exp_duty [NUM_PWM];
    byte_t exp_upload_q [$];

    int error_count;
    int test_count;
    int failed_tests;
    int upload_count;
    int errors_at_start;
    int match_idx;

    cmd_top i_dut (
        .clk            (clk),
        .reset_i        (reset_i),
        .host_data_i    (host_data_i),
        .host_valid_i   (host_valid_i),
        .upload_data_o  (upload_data_o),
        .upload_valid_o (upload_valid_o),
        .pwm_pins_o     (pwm_pins_o),
        .uart_rx_i      (uart_rx_i),
        .uart_tx_o      (uart_tx_o),
        .dac_data_o     (dac_data_o),
        .led_o          (led_o)
    );

    // uart loopback
    assign uart_rx_i = uart_tx_o;

    initial clk = 1'b0;
    always #10 clk = ~clk;

    // ==================================================
    // compare tasks
    // ==================================================
    task automatic check_byte(input string name, input byte_t exp, input byte_t got);
        if (got !== exp) begin
            error_count++;
            $display("Error at %0t: %s expected %h got %h", $time, name, exp, got);
        end
    endtask

    task automatic check_dac(input string name, input dac_t exp, input dac_t got);
        if (got !== exp) begin
            error_count++;
            $display("Error at %0t: %s expected %h got %h", $time, name, exp, got);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic got);
        if (got !== exp) begin
            error_count++;
            $display("Error at %0t: %s expected %b got %b", $time, name, exp, got);
        end
    endtask

    // ==================================================
    // reference model
    // ==================================================
    // effect of one frame, returns 1 when a byte goes back to the host
    function automatic bit model_frame(input byte_t cmd, input byte_t arg,
                                       input byte_t data, output byte_t up);
        bit has_up;
        has_up = 1'b0;
        up     = '0;
        case (cmd)
            CMD_PWM:  exp_duty[int'(arg) % NUM_PWM] = data;
            CMD_DAC:  exp_dac = {arg[5:0], data};
            CMD_LED:  exp_led = data[0];
            CMD_UART, CMD_ECHO: begin
                has_up = 1'b1;
                up     = data;
            end
            default: has_up = 1'b0;
        endcase
        return has_up;
    endfunction

    // upload checker, order free so echo and rx may swap
    always @(negedge clk) begin
        if (!reset_i && upload_valid_o) begin
            upload_count++;
            match_idx = -1;
            foreach (exp_upload_q[i]) begin
                if (match_idx < 0 && exp_upload_q[i] == upload_data_o) match_idx = i;
            end
            if (match_idx >= 0) begin
                exp_upload_q.delete(match_idx);
            end else if (exp_upload_q.size() > 0) begin
                check_byte("upload_data_o", exp_upload_q[0], upload_data_o);
                exp_upload_q.delete(0);
            end else begin
                error_count++;
                $display("Error at %0t: upload of %h arrived with no byte expected",
                         $time, upload_data_o);
            end
        end
    end

    // ==================================================
    // stimulus helpers
    // ==================================================
    // random gap before each byte, ends on the edge that takes the byte
    task automatic send_byte(input byte_t b);
        int gap;
        gap = $urandom % 3;
        repeat (gap) @(posedge clk);
        @(posedge clk);
        host_data_i  <= b;
        host_valid_i <= 1'b1;
        @(posedge clk);
        host_valid_i <= 1'b0;
    endtask

    task automatic send_frame(input byte_t cmd, input byte_t arg, input byte_t data);
        byte_t up;
        send_byte(SYNC_BYTE);
        send_byte(cmd);
        send_byte(arg);
        send_byte(data);
        if (model_frame(cmd, arg, data, up)) exp_upload_q.push_back(up);
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) @(posedge clk);
    endtask

    task automatic wait_uploads_done();
        int cycles;
        cycles = 0;
        while (exp_upload_q.size() != 0 && cycles < UPLOAD_TIMEOUT) begin
            @(posedge clk);
            cycles++;
        end
        if (exp_upload_q.size() != 0) begin
            error_count++;
            $display("Error at %0t: timeout, %0d upload bytes never arrived",
                     $time, exp_upload_q.size());
            exp_upload_q.delete();
        end
    endtask

    // registers settle one edge after the final byte
    task automatic check_regs();
        @(posedge clk);
        @(negedge clk);
        check_dac("dac_data_o", exp_dac, dac_data_o);
        check_bit("led_o", exp_led, led_o);
    endtask

    task automatic count_high(input int ch, output int high);
        high = 0;
        repeat (256) begin
            @(negedge clk);
            if (pwm_pins_o[ch]) high++;
        end
    endtask

    task automatic begin_test();
        errors_at_start = error_count;
    endtask

    task automatic end_test(input string name);
        test_count++;
        if (error_count > errors_at_start) begin
            failed_tests++;
            $display("test %s: %0d errors", name, error_count - errors_at_start);
        end else begin
            $display("test %s: ok", name);
        end
    endtask

    // ==================================================
    // tests
    // ==================================================
    task automatic test_reset();
        begin_test();
        check_dac("dac_data_o", '0, dac_data_o);
        check_bit("led_o", 1'b0, led_o);
        check_bit("uart_tx_o", 1'b1, uart_tx_o);
        check_bit("upload_valid_o", 1'b0, upload_valid_o);
        for (int i = 0; i < NUM_PWM; i++) begin
            check_bit($sformatf("pwm_pins_o[%0d]", i), 1'b0, pwm_pins_o[i]);
        end
        end_test("reset values");
    endtask

    task automatic test_led_dac();
        byte_t cmd;
        begin_test();
        repeat (8) begin
            cmd = ($urandom % 2) ? CMD_DAC : CMD_LED;
            send_frame(cmd, 8'($urandom), 8'($urandom));
            check_regs();
        end
        end_test("led and dac frames");
    endtask

    task automatic test_pwm();
        byte_t arg;
        int    ch;
        int    high;
        begin_test();
        repeat (4) begin
            arg = 8'($urandom);
            ch  = int'(arg) % NUM_PWM;
            send_frame(CMD_PWM, arg, 8'($urandom));
            idle_cycles(2);
            count_high(ch, high);
            check_byte($sformatf("pwm_pins_o[%0d] high count", ch), exp_duty[ch], 8'(high));
            check_bit("pwm high count overflow", 1'b0, high > 255);
        end
        end_test("pwm duty");
    endtask

    task automatic test_uart_loop();
        begin_test();
        repeat (3) begin
            send_frame(CMD_UART, 8'($urandom), 8'($urandom));
            wait_uploads_done();
            idle_cycles(2 * CLKS_PER_BIT);
        end
        end_test("uart loopback");
    endtask

    task automatic test_echo_in_flight();
        int start;
        begin_test();
        start = upload_count;
        send_frame(CMD_UART, 8'($urandom), 8'($urandom));
        send_frame(CMD_ECHO, 8'($urandom), 8'($urandom));
        wait_uploads_done();
        // late duplicates would show up here
        idle_cycles(2 * CLKS_PER_BIT);
        check_byte("upload count", 8'd2, 8'(upload_count - start));
        end_test("echo during uart");
    endtask

    task automatic test_stray();
        int    start;
        byte_t b;
        begin_test();
        start = upload_count;
        repeat (5) begin
            b = 8'($urandom);
            if (b == SYNC_BYTE) b = 8'h5A;
            send_byte(b);
        end
        // codes above 0x05 are unknown
        send_frame(8'(6 + $urandom % 250), 8'($urandom), 8'($urandom));
        check_regs();
        idle_cycles(2 * CLKS_PER_BIT);
        check_byte("upload count", 8'd0, 8'(upload_count - start));
        send_frame(CMD_LED, 8'($urandom), {7'($urandom), ~exp_led});
        check_regs();
        end_test("stray bytes and unknown command");
    endtask

    // ==================================================
    // main sequence
    // ==================================================
    initial begin
        void'($urandom(32'h14fd_58ea));
        reset_i      = 1'b1;
        host_data_i  = '0;
        host_valid_i = 1'b0;
        exp_dac      = '0;
        exp_led      = 1'b0;
        for (int i = 0; i < NUM_PWM; i++) begin
            exp_duty[i] = '0;
        end
        error_count  = 0;
        test_count   = 0;
        failed_tests = 0;
        upload_count = 0;

        repeat (RESET_CYCLES) @(posedge clk);
        reset_i <= 1'b0;
        @(negedge clk);

        test_reset();
        test_led_dac();
        test_pwm();
        test_uart_loop();
        test_echo_in_flight();
        test_stray();

        $display("%0d tests, %0d failed, %0d errors", test_count, failed_tests, error_count);
        if (error_count == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    // run limit
    initial begin
        repeat (RUN_LIMIT) @(posedge clk);
        $display("timeout: the run did not finish within %0d cycles", RUN_LIMIT);
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

// ==== vlog.f ====
hw/cmd_pkg.sv
hw/frame_parser.sv
hw/pwm_bank.sv
hw/uart_bridge.sv
hw/upload_arbiter.sv
hw/cmd_top.sv
verif/cmd_props.sv
verif/cmd_tb.sv

// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = cmd_tb
FILELIST = vlog.f
LOG      = sim.log
FAIL_MSG = ERRORS FOUND
PASS_MSG = NO ERRORS

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build and run the testbench with $(SIM)"
	@echo "  clean  remove the build folder and the log"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -o V$(TOP)
	./obj_dir/V$(TOP) | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation ended early"; exit 1; fi

clean:
	rm -rf obj_dir $(LOG)
